/* tb/game_vectors.txt */
// launch_key  left_right_keys  hold_in_strobes  expected_status
// status hex digits are state, hits, misses; a hold of 00 ends the list
0 0 02 000
0 2 0f 000
0 0 4b 000
0 1 14 000
0 0 48 000
1 0 01 100
0 0 10 210
0 0 03 210
0 0 01 010
0 0 01 010
1 0 01 110
1 0 0a 110
0 0 08 311
0 0 04 011
0 0 00 000

/* verilog.f */
hdl/vga_pkg.sv
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/sprite_unit.sv
hdl/pixel_mixer.sv
hdl/game_control.sv
hdl/game_top.sv
tb/tb_game_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_game_top -o sim_game

# the testbench exit status is lost in the pipe, the log decides
./obj_dir/sim_game | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation finished, see sim.log"
exit 0

/* tb/tb_game_top.sv */
`default_nettype none

module tb_game_top;

    // small screen so that a frame is only a few strobes long
    localparam int clk_mhz      = 25;
    localparam int pixel_mhz    = 25;
    localparam int strobe_width = 4;
    localparam int h_active     = 32;
    localparam int h_front      = 2;
    localparam int h_sync       = 4;
    localparam int h_back       = 2;
    localparam int v_active     = 24;
    localparam int v_front      = 1;
    localparam int v_sync       = 2;
    localparam int v_back       = 1;

    localparam int strobe_clocks = 2 ** strobe_width;
    localparam int h_total       = h_active + h_front + h_sync + h_back;
    localparam int v_total       = v_active + v_front + v_sync + v_back;
    localparam int frame_strobes = h_total * v_total / strobe_clocks;
    localparam int launcher_max  = h_active - game_pkg::launcher_w;
    localparam int launcher_home = (h_active - game_pkg::launcher_w) / 2;
    localparam int max_vectors   = 64;

    logic                   clk;
    logic                   reset;
    logic                   launch_key;
    logic [1:0]             left_right_keys;
    logic                   hsync;
    logic                   vsync;
    logic                   display_on;
    vga_pkg::rgb_t          rgb;
    game_pkg::game_status_t status;

    // launch_key, keys, hold and status words for each vector
    logic [15:0] vec_mem [0:255];
    int          n_vectors;
    int          total_strobes;
    logic        vectors_ready;

    // launcher reference position
    int tick;
    int lx_model;
    int lx_view;

    // monitor state
    int   hs_low;
    int   vs_low;
    int   on_run;
    int   line_clocks;
    int   lines_in_frame;
    int   x;
    int   line;
    int   sample_row;
    int   colour_checks;
    logic hs_prev;
    logic vs_prev;
    logic on_prev;
    logic line_seen;

    game_top
    #(
        .clk_mhz      ( clk_mhz      ),
        .pixel_mhz    ( pixel_mhz    ),
        .strobe_width ( strobe_width ),
        .h_active     ( h_active     ),
        .h_front      ( h_front      ),
        .h_sync       ( h_sync       ),
        .h_back       ( h_back       ),
        .v_active     ( v_active     ),
        .v_front      ( v_front      ),
        .v_sync       ( v_sync       ),
        .v_back       ( v_back       )
    )
    i_dut
    (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .launch_key      ( launch_key      ),
        .left_right_keys ( left_right_keys ),
        .hsync           ( hsync           ),
        .vsync           ( vsync           ),
        .display_on      ( display_on      ),
        .rgb             ( rgb             ),
        .status          ( status          )
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [15:0] vec_word(input int idx, input int field);
        logic [7:0] addr;
        addr = 8'(idx * 4 + field);
        return vec_mem[addr];
    endfunction

    // --------------------
    // launcher moves one pixel per strobe and stops at the screen edges

    always @(posedge clk) begin
        if (reset) begin
            tick     <= 0;
            lx_model <= launcher_home;
        end else begin
            tick <= tick + 1;
            if ((tick + 1) % strobe_clocks == 0) begin
                if (left_right_keys == 2'b10)
                    lx_model <= (lx_model < launcher_max) ? lx_model + 1 : launcher_max;
                else if (left_right_keys == 2'b01)
                    lx_model <= (lx_model > 0) ? lx_model - 1 : 0;
            end
        end
        // rgb shows the sprite one clock behind
        lx_view <= lx_model;
    end

    // --------------------
    // sync timing and colour monitor

    always @(negedge clk) begin
        if (reset) begin
            hs_low         = 0;
            vs_low         = 0;
            on_run         = 0;
            line_clocks    = 0;
            lines_in_frame = 0;
            x              = 0;
            line           = 0;
            line_seen      = 1'b0;
            hs_prev        = 1'b1;
            vs_prev        = 1'b1;
            on_prev        = 1'b0;
        end else begin
            if (!hsync)
                hs_low = hs_low + 1;
            if (hsync && !hs_prev) begin
                check_value("hsync_low_clocks", 32'(hs_low), 32'(h_sync));
                hs_low = 0;
            end
            if (!hsync && hs_prev) begin
                if (line_seen)
                    check_value("line_clocks", 32'(line_clocks), 32'(h_total));
                line_seen   = 1'b1;
                line_clocks = 0;
            end
            line_clocks = line_clocks + 1;

            if (!vsync) begin
                vs_low = vs_low + 1;
                line   = 0;
                check_value("display_on_in_vsync", 32'(display_on), 32'd0);
            end
            if (vsync && !vs_prev) begin
                check_value("vsync_low_clocks", 32'(vs_low), 32'(v_sync * h_total));
                vs_low = 0;
            end
            if (!vsync && vs_prev) begin
                check_value("active_lines", 32'(lines_in_frame), 32'(v_active));
                lines_in_frame = 0;
                sample_row = $urandom_range(v_active - 1, v_active - game_pkg::launcher_h);
            end

            if (display_on && !on_prev)
                lines_in_frame = lines_in_frame + 1;
            if (display_on)
                on_run = on_run + 1;
            if (!display_on && on_prev) begin
                check_value("display_on_clocks", 32'(on_run), 32'(h_active));
                on_run = 0;
                line   = line + 1;
            end

            if (!display_on) begin
                check_value("rgb_blank", 32'(rgb), 32'(vga_pkg::col_black));
                x = 0;
            end else begin
                if (line == sample_row) begin
                    if (x >= lx_view && x < lx_view + game_pkg::launcher_w)
                        check_value("rgb", 32'(rgb), 32'(vga_pkg::col_launcher));
                    else
                        check_value("rgb", 32'(rgb), 32'(vga_pkg::col_black));
                    if (x == 0)
                        colour_checks = colour_checks + 1;
                end
                x = x + 1;
            end

            hs_prev = hsync;
            vs_prev = vsync;
            on_prev = display_on;
        end
    end

    // --------------------
    // watchdog

    initial begin
        wait (vectors_ready);
        repeat ((total_strobes + 2 * frame_strobes) * strobe_clocks * 2) @(posedge clk);
        $display("ERROR: simulation timed out before the vectors were done");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    // --------------------
    // vector stimulus

    initial begin
        int          idx;
        logic [31:0] expected_status;
        clk             = 1'b0;
        reset           = 1'b1;
        launch_key      = 1'b0;
        left_right_keys = 2'b00;
        vectors_ready   = 1'b0;
        colour_checks   = 0;
        void'($urandom(67916));
        sample_row = $urandom_range(v_active - 1, v_active - game_pkg::launcher_h);

        $readmemh("tb/game_vectors.txt", vec_mem);
        n_vectors     = 0;
        total_strobes = 0;
        // a hold of zero ends the list
        while (n_vectors < max_vectors && vec_word(n_vectors, 2) != 16'h0) begin
            total_strobes = total_strobes + 32'(vec_word(n_vectors, 2));
            n_vectors     = n_vectors + 1;
        end
        if (n_vectors == 0) begin
            $display("ERROR: no vectors could be read from tb/game_vectors.txt");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        vectors_ready = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // idle with zero counts out of reset
        expected_status = 32'd0;
        for (idx = 0; idx < n_vectors; idx = idx + 1) begin
            launch_key      <= 1'(vec_word(idx, 0));
            left_right_keys <= 2'(vec_word(idx, 1));
            @(negedge clk);
            check_value("status", 32'(status), expected_status);
            expected_status = 32'(10'(vec_word(idx, 3)));
            repeat (32'(vec_word(idx, 2)) * strobe_clocks) @(posedge clk);
        end
        @(negedge clk);
        check_value("status", 32'(status), expected_status);

        if (colour_checks > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("ERROR: no launcher line was sampled for the colour check");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* hdl/game_top.sv */
`default_nettype none

module game_top
#(
    parameter int clk_mhz      = 50,
    parameter int pixel_mhz    = 25,
    parameter int strobe_width = 20,
    parameter int h_active     = vga_pkg::h_active,
    parameter int h_front      = vga_pkg::h_front,
    parameter int h_sync       = vga_pkg::h_sync,
    parameter int h_back       = vga_pkg::h_back,
    parameter int v_active     = vga_pkg::v_active,
    parameter int v_front      = vga_pkg::v_front,
    parameter int v_sync       = vga_pkg::v_sync,
    parameter int v_back       = vga_pkg::v_back
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   launch_key,
    input  logic [1:0]             left_right_keys,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   display_on,
    output vga_pkg::rgb_t          rgb,
    output game_pkg::game_status_t status
);

    // --------------------
    // start positions

    localparam game_pkg::sprite_t target_home = '{x: 10'd0, y: 10'd2, visible: 1'b1};
    localparam game_pkg::sprite_t torpedo_home = '{x: 10'd0, y: 10'd0, visible: 1'b0};
    localparam game_pkg::sprite_t launcher_home = '{
        x:       10'((h_active - game_pkg::launcher_w) / 2),
        y:       10'(v_active - game_pkg::launcher_h),
        visible: 1'b1
    };

    vga_pkg::pixel_pos_t    pos;
    logic                   hsync_raw;
    logic                   vsync_raw;
    logic                   display_on_raw;
    game_pkg::sprite_t      target;
    game_pkg::sprite_t      torpedo;
    game_pkg::sprite_t      launcher;
    game_pkg::sprite_move_t target_move;
    game_pkg::sprite_move_t torpedo_move;
    game_pkg::sprite_move_t launcher_move;

    vga_timing
    #(
        .clk_mhz   ( clk_mhz   ),
        .pixel_mhz ( pixel_mhz ),
        .h_active  ( h_active  ),
        .h_front   ( h_front   ),
        .h_sync    ( h_sync    ),
        .h_back    ( h_back    ),
        .v_active  ( v_active  ),
        .v_front   ( v_front   ),
        .v_sync    ( v_sync    ),
        .v_back    ( v_back    )
    )
    i_vga_timing
    (
        .clk        ( clk            ),
        .reset      ( reset          ),
        .hsync      ( hsync_raw      ),
        .vsync      ( vsync_raw      ),
        .display_on ( display_on_raw ),
        .pos        ( pos            )
    );

    game_control
    #(
        .strobe_width ( strobe_width ),
        .h_active     ( h_active     ),
        .v_active     ( v_active     )
    )
    i_game_control
    (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .launch_key      ( launch_key      ),
        .left_right_keys ( left_right_keys ),
        .target          ( target          ),
        .torpedo         ( torpedo         ),
        .launcher        ( launcher        ),
        .target_move     ( target_move     ),
        .torpedo_move    ( torpedo_move    ),
        .launcher_move   ( launcher_move   ),
        .status          ( status          )
    );

    // --------------------
    // sprites

    sprite_unit
    #(
        .limit ( h_active            ),
        .size  ( game_pkg::target_w  ),
        .wrap  ( 1'b1                ),
        .axis  ( 1'b0                )
    )
    i_target
    (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .reset_pos ( target_home ),
        .move      ( target_move ),
        .sprite    ( target      )
    );

    // moves up, so it stops at row zero
    sprite_unit
    #(
        .limit ( v_active            ),
        .size  ( game_pkg::torpedo_h ),
        .wrap  ( 1'b0                ),
        .axis  ( 1'b1                )
    )
    i_torpedo
    (
        .clk       ( clk          ),
        .reset     ( reset        ),
        .reset_pos ( torpedo_home ),
        .move      ( torpedo_move ),
        .sprite    ( torpedo      )
    );

    sprite_unit
    #(
        .limit ( h_active             ),
        .size  ( game_pkg::launcher_w ),
        .wrap  ( 1'b0                 ),
        .axis  ( 1'b0                 )
    )
    i_launcher
    (
        .clk       ( clk           ),
        .reset     ( reset         ),
        .reset_pos ( launcher_home ),
        .move      ( launcher_move ),
        .sprite    ( launcher      )
    );

    pixel_mixer i_pixel_mixer
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pos      ( pos      ),
        .target   ( target   ),
        .torpedo  ( torpedo  ),
        .launcher ( launcher ),
        .rgb      ( rgb      )
    );

    // match the registered colour
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            display_on <= 1'b0;
        end else begin
            hsync      <= hsync_raw;
            vsync      <= vsync_raw;
            display_on <= display_on_raw;
        end
    end

endmodule

`default_nettype wire

/* hdl/game_control.sv */
`default_nettype none

module game_control
#(
    parameter int strobe_width = 20,
    parameter int h_active     = 640,
    parameter int v_active     = 480
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   launch_key,
    input  logic [1:0]             left_right_keys,
    input  game_pkg::sprite_t      target,
    input  game_pkg::sprite_t      torpedo,
    input  game_pkg::sprite_t      launcher,
    output game_pkg::sprite_move_t target_move,
    output game_pkg::sprite_move_t torpedo_move,
    output game_pkg::sprite_move_t launcher_move,
    output game_pkg::game_status_t status
);

    localparam int hold_w = $clog2(game_pkg::result_hold);

    logic [strobe_width-1:0] strobe_cnt;
    logic                    strobe;
    logic                    launch_req;
    logic [hold_w-1:0]       hold_cnt;
    logic                    overlap;
    logic                    at_top;
    game_pkg::sprite_t       torpedo_start;

    assign strobe = &strobe_cnt;

    // --------------------
    // collision and top row

    assign overlap = ({1'b0, torpedo.x} < {1'b0, target.x} + 11'(game_pkg::target_w))
                  && ({1'b0, target.x} < {1'b0, torpedo.x} + 11'(game_pkg::torpedo_w))
                  && ({1'b0, torpedo.y} < {1'b0, target.y} + 11'(game_pkg::target_h))
                  && ({1'b0, target.y} < {1'b0, torpedo.y} + 11'(game_pkg::torpedo_h));

    assign at_top = (torpedo.y == 10'd0);

    // centred just above the launcher
    assign torpedo_start = '{
        x:       launcher.x + 10'(game_pkg::launcher_w / 2 - game_pkg::torpedo_w / 2),
        y:       10'(v_active - game_pkg::launcher_h - game_pkg::torpedo_h),
        visible: 1'b1
    };

    // --------------------
    // move commands

    always_comb begin
        target_move            = '0;
        target_move.step_pos   = strobe;
        launcher_move          = '0;
        launcher_move.step_pos = strobe && left_right_keys == 2'b10;
        launcher_move.step_neg = strobe && left_right_keys == 2'b01;
        torpedo_move           = '0;
        if (strobe) begin
            case (status.state)
                game_pkg::idle: begin
                    torpedo_move.load       = launch_req;
                    torpedo_move.load_value = torpedo_start;
                end
                game_pkg::flying: begin
                    if (overlap || at_top) begin
                        torpedo_move.load       = 1'b1;
                        torpedo_move.load_value = '{x: torpedo.x, y: torpedo.y, visible: 1'b0};
                    end else begin
                        torpedo_move.step_neg = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // state and score

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_cnt <= '0;
            launch_req <= 1'b0;
            hold_cnt   <= '0;
            status     <= '{state: game_pkg::idle, hits: 4'd0, misses: 4'd0};
        end else begin
            strobe_cnt <= strobe_cnt + 1'b1;

            // keys pressed outside idle are dropped
            if (status.state != game_pkg::idle || strobe)
                launch_req <= 1'b0;
            else if (launch_key)
                launch_req <= 1'b1;

            if (strobe) begin
                case (status.state)
                    game_pkg::idle: begin
                        if (launch_req)
                            status.state <= game_pkg::flying;
                    end
                    game_pkg::flying: begin
                        hold_cnt <= '0;
                        if (overlap) begin
                            status.state <= game_pkg::hit;
                            if (status.hits != 4'hf)
                                status.hits <= status.hits + 1'b1;
                        end else if (at_top) begin
                            status.state <= game_pkg::miss;
                            if (status.misses != 4'hf)
                                status.misses <= status.misses + 1'b1;
                        end
                    end
                    default: begin
                        if (hold_cnt == hold_w'(game_pkg::result_hold - 1))
                            status.state <= game_pkg::idle;
                        else
                            hold_cnt <= hold_cnt + 1'b1;
                    end
                endcase
            end
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        status.state inside {game_pkg::idle, game_pkg::flying, game_pkg::hit, game_pkg::miss});
    a_torpedo_in_flight: assert property (@(posedge clk) disable iff (reset)
        torpedo.visible == (status.state == game_pkg::flying));
    a_torpedo_column: assert property (@(posedge clk) disable iff (reset)
        torpedo.visible |-> {1'b0, torpedo.x} + 11'(game_pkg::torpedo_w) <= 11'(h_active));

endmodule

`default_nettype wire

/* hdl/pixel_mixer.sv */
`default_nettype none

module pixel_mixer
(
    input  logic                clk,
    input  logic                reset,
    input  vga_pkg::pixel_pos_t pos,
    input  game_pkg::sprite_t   target,
    input  game_pkg::sprite_t   torpedo,
    input  game_pkg::sprite_t   launcher,
    output vga_pkg::rgb_t       rgb
);

    logic on_target;
    logic on_torpedo;
    logic on_launcher;

    // is the pixel inside a visible w x h rectangle
    function automatic logic covers(
        input vga_pkg::pixel_pos_t p,
        input game_pkg::sprite_t   s,
        input int                  w,
        input int                  h
    );
        logic in_x;
        logic in_y;
        in_x = (p.x >= s.x) && ({1'b0, p.x} < {1'b0, s.x} + 11'(w));
        in_y = (p.y >= s.y) && ({1'b0, p.y} < {1'b0, s.y} + 11'(h));
        return s.visible && in_x && in_y;
    endfunction

    assign on_target   = covers(pos, target, game_pkg::target_w, game_pkg::target_h);
    assign on_torpedo  = covers(pos, torpedo, game_pkg::torpedo_w, game_pkg::torpedo_h);
    assign on_launcher = covers(pos, launcher, game_pkg::launcher_w, game_pkg::launcher_h);

    // --------------------
    // colour, torpedo drawn on top

    always_ff @(posedge clk) begin
        if (reset)
            rgb <= vga_pkg::col_black;
        else if (!pos.valid)
            rgb <= vga_pkg::col_black;
        else if (on_torpedo)
            rgb <= vga_pkg::col_torpedo;
        else if (on_target)
            rgb <= vga_pkg::col_target;
        else if (on_launcher)
            rgb <= vga_pkg::col_launcher;
        else
            rgb <= vga_pkg::col_black;
    end

endmodule

`default_nettype wire

/* hdl/sprite_unit.sv */
`default_nettype none

module sprite_unit
#(
    parameter int limit = 640,
    parameter int size  = 8,
    parameter bit wrap  = 1'b0,
    parameter bit axis  = 1'b0
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  game_pkg::sprite_t     reset_pos,
    input  game_pkg::sprite_move_t move,
    output game_pkg::sprite_t     sprite
);

    // last position that keeps the whole sprite on screen
    localparam logic [9:0] max_pos = 10'(limit - size);

    logic [9:0] cur;
    logic [9:0] nxt;

    assign cur = axis ? sprite.y : sprite.x;

    // --------------------
    // next coordinate on the moving axis

    always_comb begin
        nxt = cur;
        if (move.step_pos) begin
            if (cur >= max_pos)
                nxt = wrap ? 10'd0 : max_pos;
            else
                nxt = cur + 1'b1;
        end else if (move.step_neg) begin
            if (cur == 10'd0)
                nxt = wrap ? max_pos : 10'd0;
            else
                nxt = cur - 1'b1;
        end
    end

    // --------------------
    // position register

    always_ff @(posedge clk) begin
        if (reset) begin
            sprite <= reset_pos;
        end else if (move.load) begin
            sprite <= move.load_value;
        end else if (move.step_pos || move.step_neg) begin
            if (axis)
                sprite.y <= nxt;
            else
                sprite.x <= nxt;
        end
    end

    // covers loads coming from the game control as well
    a_on_screen: assert property (@(posedge clk) disable iff (reset)
        cur <= max_pos);

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
`default_nettype none

module vga_timing
#(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25,
    parameter int h_active  = 640,
    parameter int h_front   = 16,
    parameter int h_sync    = 96,
    parameter int h_back    = 48,
    parameter int v_active  = 480,
    parameter int v_front   = 10,
    parameter int v_sync    = 2,
    parameter int v_back    = 33
)
(
    input  logic                clk,
    input  logic                reset,
    output logic                hsync,
    output logic                vsync,
    output logic                display_on,
    output vga_pkg::pixel_pos_t pos
);

    localparam int div     = clk_mhz / pixel_mhz;
    localparam int div_w   = (div > 1) ? $clog2(div) : 1;
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // sync windows start after the front porch
    localparam int hs_start = h_active + h_front;
    localparam int vs_start = v_active + v_front;

    logic [div_w-1:0] div_cnt;
    logic             pixel_en;
    logic [9:0]       x_cnt;
    logic [9:0]       y_cnt;
    logic             active;

    // --------------------
    // pixel enable

    assign pixel_en = (div_cnt == div_w'(div - 1));

    always_ff @(posedge clk) begin
        if (reset || pixel_en)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // --------------------
    // counters

    always_ff @(posedge clk) begin
        if (reset) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (pixel_en) begin
            if (x_cnt == 10'(h_total - 1)) begin
                x_cnt <= '0;
                if (y_cnt == 10'(v_total - 1))
                    y_cnt <= '0;
                else
                    y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign active = (x_cnt < 10'(h_active)) && (y_cnt < 10'(v_active));

    // outputs one cycle behind the counters, all aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            display_on <= 1'b0;
            pos        <= '0;
        end else begin
            hsync      <= !(x_cnt >= 10'(hs_start) && x_cnt < 10'(hs_start + h_sync));
            vsync      <= !(y_cnt >= 10'(vs_start) && y_cnt < 10'(vs_start + v_sync));
            display_on <= active;
            pos        <= '{x: x_cnt, y: y_cnt, valid: active};
        end
    end

    a_x_in_line: assert property (@(posedge clk) disable iff (reset)
        x_cnt < 10'(h_total));
    a_y_in_frame: assert property (@(posedge clk) disable iff (reset)
        y_cnt < 10'(v_total));

endmodule

`default_nettype wire

/* hdl/game_pkg.sv */
`default_nettype none

package game_pkg;

    // --------------------
    // game state and status

    typedef enum logic [1:0] {
        idle   = 2'd0,
        flying = 2'd1,
        hit    = 2'd2,
        miss   = 2'd3
    } game_state_t;

    // hits and misses saturate at 15
    typedef struct packed {
        game_state_t state;
        logic [3:0]  hits;
        logic [3:0]  misses;
    } game_status_t;

    // --------------------
    // sprites

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       visible;
    } sprite_t;

    // one-cycle command, valid with the update strobe
    typedef struct packed {
        logic    step_pos;
        logic    step_neg;
        logic    load;
        sprite_t load_value;
    } sprite_move_t;

    // sizes in pixels
    localparam int target_w   = 8;
    localparam int target_h   = 4;
    localparam int torpedo_w  = 2;
    localparam int torpedo_h  = 4;
    localparam int launcher_w = 8;
    localparam int launcher_h = 3;

    // strobes spent in hit or miss before going back to idle
    localparam int result_hold = 4;

endpackage

`default_nettype wire

/* hdl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // --------------------
    // display types

    // red, green, blue from msb to lsb
    typedef logic [2:0] rgb_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       valid;
    } pixel_pos_t;

    // --------------------
    // default 640x480 timing, in pixels and lines

    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;

    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;

    // --------------------
    // colours

    localparam rgb_t col_black    = 3'b000;
    localparam rgb_t col_target   = 3'b100;
    localparam rgb_t col_torpedo  = 3'b110;
    localparam rgb_t col_launcher = 3'b010;

endpackage

`default_nettype wire
